// ==== verilog/timing_pkg.sv ====
package timing_pkg;

    // the eight timing phases of one frame, in the order they occur
    typedef enum logic [2:0] {
        V1 = 3'd0,
        W2 = 3'd1,
        X1 = 3'd2,
        X7 = 3'd3,
        Y6 = 3'd4,
        Y7 = 3'd5,
        Z2 = 3'd6,
        Z6 = 3'd7
    } phase_e;

    // one strobe per phase, exactly one high in any clock
    typedef struct packed {
        logic v1;
        logic w2;
        logic x1;
        logic x7;
        logic y6;
        logic y7;
        logic z2;
        logic z6;
    } phase_t;

endpackage

// ==== verilog/sampler_pkg.sv ====
package sampler_pkg;

    // state of one base-3 gate digit
    typedef enum logic [1:0] {
        GT1 = 2'd0,
        GT2 = 2'd1,
        GT3 = 2'd2
    } gt_e;

    typedef struct packed {
        gt_e c4;
        gt_e c3;
        gt_e c2;
        gt_e c1;
    } gate_cnt_t;

    // discrete inputs, raw at the top level and buffered inside
    typedef struct packed {
        logic cr1;
        logic cr2;
        logic gc1;
        logic gc2;
        logic din11;
        logic din12;
        logic ssfb2;
        logic ssfb3;
    } disc_t;

    typedef struct packed {
        logic crcav;
        logic icsd;
        logic pbg2v;
        logic pcg2v;
        logic paav;
        logic pcav;
        logic lgav;
        logic dls;
        logic etcr;
        logic domc1;
        logic diad;
        logic ssa;
        logic resmv;
        logic mlav;
        logic c4rdn;
        logic g1dv;
        logic g2dv;
        logic g3dv;
        logic g6dv;
        logic g7dv;
    } qual_t;

    typedef struct packed {
        logic dc1;
        logic dc2;
        logic dc3;
        logic dc4;
        logic ml1_2;
    } status_t;

endpackage

// ==== verilog/phase_gen.sv ====
module phase_gen
    import timing_pkg::*;
(
    input  logic   sim_clk,
    input  logic   arst_n,
    output phase_t phase,
    output logic   frame_end
);

    phase_e state;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= V1;
        end else begin
            state <= (state == Z6) ? V1 : phase_e'(state + 3'd1);
        end
    end

    // one-hot strobes straight from the phase register
    always_comb begin
        phase = '0;
        case (state)
            V1: phase.v1 = 1'b1;
            W2: phase.w2 = 1'b1;
            X1: phase.x1 = 1'b1;
            X7: phase.x7 = 1'b1;
            Y6: phase.y6 = 1'b1;
            Y7: phase.y7 = 1'b1;
            Z2: phase.z2 = 1'b1;
            default: phase.z6 = 1'b1;
        endcase
    end

    assign frame_end = (state == Z6);

endmodule

// ==== verilog/gate_counter.sv ====
module gate_counter
    import sampler_pkg::*;
(
    input  logic      sim_clk,
    input  logic      arst_n,
    input  logic      frame_end,
    output gate_cnt_t gates
);

    logic step_c2;
    logic step_c3;
    logic step_c4;

    function automatic gt_e gt_next(input gt_e d);
        case (d)
            GT1: gt_next = GT2;
            GT2: gt_next = GT3;
            default: gt_next = GT1;
        endcase
    endfunction

    // a digit steps when every digit below it wraps in the same frame
    assign step_c2 = frame_end && (gates.c1 == GT3);
    assign step_c3 = step_c2 && (gates.c2 == GT3);
    assign step_c4 = step_c3 && (gates.c3 == GT3);

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            gates.c1 <= GT1;
            gates.c2 <= GT1;
            gates.c3 <= GT1;
            gates.c4 <= GT1;
        end else begin
            if (frame_end) begin
                gates.c1 <= gt_next(gates.c1);
            end
            if (step_c2) begin
                gates.c2 <= gt_next(gates.c2);
            end
            if (step_c3) begin
                gates.c3 <= gt_next(gates.c3);
            end
            if (step_c4) begin
                gates.c4 <= gt_next(gates.c4);
            end
        end
    end

endmodule

// ==== verilog/dia_bank.sv ====
module dia_bank
    import sampler_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic  sim_clk,
    input  logic  arst_n,
    input  disc_t disc,
    output disc_t disc_s
);

    disc_t sync_q [SYNC_STAGES];

    // plain shift chain, stage 0 takes the raw discretes
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= disc;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign disc_s = sync_q[SYNC_STAGES-1];

endmodule

// ==== verilog/sd_sampler.sv ====
module sd_sampler
    import timing_pkg::*;
    import sampler_pkg::*;
(
    input  logic      sim_clk,
    input  logic      arst_n,
    input  phase_t    phase,
    input  gate_cnt_t gates,
    input  qual_t     qual,
    input  disc_t     disc_s,
    output status_t   status
);

    logic cr1_n, cr2_n, gc1_n, gc2_n;
    logic din11_n, din12_n, ssfb2_n, ssfb3_n;
    logic icsd_n, etcr_n, c4rdn_n;
    logic g1dv_n, g3dv_n, g6dv_n, g7dv_n;

    logic x7_clr, y6_clr;
    logic dc1_set, dc1_clr;
    logic dc2_set, dc2_clr;
    logic dc3_set, dc3_clr;
    logic dc4_set, dc4_clr;
    logic ml_set, ml_clr;

    assign cr1_n   = ~disc_s.cr1;
    assign cr2_n   = ~disc_s.cr2;
    assign gc1_n   = ~disc_s.gc1;
    assign gc2_n   = ~disc_s.gc2;
    assign din11_n = ~disc_s.din11;
    assign din12_n = ~disc_s.din12;
    assign ssfb2_n = ~disc_s.ssfb2;
    assign ssfb3_n = ~disc_s.ssfb3;
    assign icsd_n  = ~qual.icsd;
    assign etcr_n  = ~qual.etcr;
    assign c4rdn_n = ~qual.c4rdn;
    assign g1dv_n  = ~qual.g1dv;
    assign g3dv_n  = ~qual.g3dv;
    assign g6dv_n  = ~qual.g6dv;
    assign g7dv_n  = ~qual.g7dv;

    //////////////////////////////
    // delay counter sample flags
    //////////////////////////////

    // clears shared between several flags
    assign x7_clr = phase.x7 & qual.pcg2v & etcr_n & qual.lgav;
    assign y6_clr = phase.y6 & qual.paav & g1dv_n & g7dv_n;

    assign dc1_set = phase.x7 & qual.dls & (gates.c1 == GT3);
    assign dc1_clr = (phase.z6 & qual.paav & g6dv_n & qual.g7dv) | x7_clr;

    assign dc2_set = phase.x7 & qual.dls & (gates.c2 == GT3) & (gates.c1 != GT3);
    assign dc2_clr = y6_clr | x7_clr;

    assign dc3_set = phase.x7 & qual.dls & qual.etcr & (gates.c3 == GT3);
    assign dc3_clr = dc2_clr;

    assign dc4_set = phase.x7 & qual.dls & qual.etcr & qual.domc1 & (gates.c4 == GT3);
    assign dc4_clr = y6_clr
                   | (phase.y6 & qual.lgav & qual.pcav & qual.g2dv & g3dv_n & etcr_n);

    //////////////////////////////
    // mode latch
    //////////////////////////////

    // the nine set products, one per line
    assign ml_set = (phase.y7 & qual.icsd & qual.pbg2v & qual.crcav & cr1_n)
                  | (phase.y7 & qual.paav & g1dv_n & g7dv_n & c4rdn_n)
                  | (phase.x1 & qual.icsd & qual.pcg2v & qual.crcav & cr2_n)
                  | (phase.z2 & icsd_n & qual.crcav & qual.pbg2v & gc1_n)
                  | (phase.z2 & ssfb2_n & qual.ssa & qual.pbg2v)
                  | (phase.w2 & icsd_n & qual.crcav & qual.pcg2v & gc2_n)
                  | (phase.z2 & din11_n & qual.pbg2v & qual.diad)
                  | (phase.w2 & din12_n & qual.pcg2v & qual.diad)
                  | (phase.x1 & ssfb3_n & qual.pcg2v & qual.ssa);

    assign ml_clr = phase.z2 & qual.resmv & qual.mlav;

    //////////////////////////////
    // latch registers
    //////////////////////////////

    // clear beats set, otherwise the latch holds
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            status <= '0;
        end else begin
            if (dc1_clr) status.dc1 <= 1'b0;
            else if (dc1_set) status.dc1 <= 1'b1;
            if (dc2_clr) status.dc2 <= 1'b0;
            else if (dc2_set) status.dc2 <= 1'b1;
            if (dc3_clr) status.dc3 <= 1'b0;
            else if (dc3_set) status.dc3 <= 1'b1;
            if (dc4_clr) status.dc4 <= 1'b0;
            else if (dc4_set) status.dc4 <= 1'b1;
            if (ml_clr) status.ml1_2 <= 1'b0;
            else if (ml_set) status.ml1_2 <= 1'b1;
        end
    end

endmodule

// ==== verilog/sd_sampler_top.sv ====
module sd_sampler_top
    import timing_pkg::*;
    import sampler_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic      sim_clk,
    input  logic      arst_n,
    input  disc_t     disc,
    input  qual_t     qual,
    output status_t   status,
    output phase_t    phase,
    output gate_cnt_t gates
);

    logic  frame_end;
    disc_t disc_s;

    phase_gen u_phase_gen (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .phase     (phase),
        .frame_end (frame_end)
    );

    gate_counter u_gate_counter (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .frame_end (frame_end),
        .gates     (gates)
    );

    // discretes are asynchronous, so they only reach the sampler buffered
    dia_bank #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_dia_bank (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .disc    (disc),
        .disc_s  (disc_s)
    );

    sd_sampler u_sd_sampler (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .gates   (gates),
        .qual    (qual),
        .disc_s  (disc_s),
        .status  (status)
    );

endmodule

// ==== testbench/sd_sampler_sva.sv ====
module sd_sampler_sva
    import timing_pkg::*;
    import sampler_pkg::*;
(
    input logic      sim_clk,
    input logic      arst_n,
    input phase_t    phase,
    input gate_cnt_t gates,
    input qual_t     qual,
    input status_t   status
);

    int unsigned fail_cnt = 0;

    a_phase_onehot: assert property (@(posedge sim_clk) disable iff (!arst_n) $onehot(phase))
        else begin
            fail_cnt++;
            $error("phase strobes are not one-hot: %h", phase);
        end

    // encoding 2'b11 is not a gate state
    a_gate_legal: assert property (@(posedge sim_clk) disable iff (!arst_n)
        gates.c1 != 2'b11 && gates.c2 != 2'b11 && gates.c3 != 2'b11 && gates.c4 != 2'b11)
        else begin
            fail_cnt++;
            $error("gate digit holds an illegal encoding: %h", gates);
        end

    a_ml_clear: assert property (@(posedge sim_clk) disable iff (!arst_n)
        (phase.z2 && qual.resmv && qual.mlav) |=> !status.ml1_2)
        else begin
            fail_cnt++;
            $error("ml1_2 still high after a Z2 clear");
        end

endmodule

bind sd_sampler_top sd_sampler_sva u_sd_sampler_sva (
    .sim_clk (sim_clk),
    .arst_n  (arst_n),
    .phase   (phase),
    .gates   (gates),
    .qual    (qual),
    .status  (status)
);

// ==== testbench/tb_sd_sampler.sv ====
module tb_sd_sampler
    import timing_pkg::*;
    import sampler_pkg::*;
;

    localparam int SYNC_STAGES = 2;
    localparam int SEED = 32'hc95c_298a;

    logic      sim_clk;
    logic      arst_n;
    disc_t     disc;
    qual_t     qual;
    status_t   status;
    phase_t    phase;
    gate_cnt_t gates;

    disc_t   row_disc[$];
    qual_t   row_qual[$];
    int      row_frames[$];
    status_t row_status[$];
    bit      row_checked[$];
    int      errors = 0;
    int      limit_cycles = 0;
    int      m_slot;
    int      m_frame;
    status_t m_status;
    disc_t   m_sync [SYNC_STAGES];
    status_t exp_end;
    bit      end_pending = 1'b0;

    sd_sampler_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sd_sampler_top (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .disc    (disc),
        .qual    (qual),
        .status  (status),
        .phase   (phase),
        .gates   (gates)
    );

    initial begin
        sim_clk = 1'b0;
        forever #20 sim_clk = ~sim_clk;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_phase(input phase_t exp, input phase_t act);
        if (act !== exp) begin
            errors++;
            $display("error phase: expected %h, got %h", exp, act);
        end
    endtask

    task automatic check_gates(input gate_cnt_t exp, input gate_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("error gates: expected %h, got %h", exp, act);
        end
    endtask

    task automatic check_status(input status_t exp, input status_t act);
        if (act !== exp) begin
            errors++;
            $display("error status: expected %h, got %h", exp, act);
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // frame number 0..80 written out as four base-3 digits
    function automatic gate_cnt_t count_to_gates(input int n);
        gate_cnt_t g;
        int d1;
        int d2;
        int d3;
        int d4;
        d1 = n % 3;
        d2 = (n / 3) % 3;
        d3 = (n / 9) % 3;
        d4 = (n / 27) % 3;
        g.c1 = gt_e'(d1[1:0]);
        g.c2 = gt_e'(d2[1:0]);
        g.c3 = gt_e'(d3[1:0]);
        g.c4 = gt_e'(d4[1:0]);
        return g;
    endfunction

    function automatic logic next_latch(input logic cur, input logic set, input logic clr);
        return clr ? 1'b0 : (set ? 1'b1 : cur);
    endfunction

    task automatic reset_model();
        m_slot = 0;
        m_frame = 0;
        m_status = '0;
        for (int i = 0; i < SYNC_STAGES; i++) begin
            m_sync[i] = '0;
        end
    endtask

    task automatic step_model();
        disc_t     ds;
        phase_e    ph;
        gate_cnt_t g;
        logic      clr_x7;
        logic      clr_y6;
        logic      ml_set;
        ds = m_sync[SYNC_STAGES-1];
        ph = phase_e'(m_slot[2:0]);
        g = count_to_gates(m_frame);
        clr_x7 = ph == X7 && qual.pcg2v && !qual.etcr && qual.lgav;
        clr_y6 = ph == Y6 && qual.paav && !qual.g1dv && !qual.g7dv;
        m_status.dc1 = next_latch(m_status.dc1, ph == X7 && qual.dls && g.c1 == GT3,
            clr_x7 || (ph == Z6 && qual.paav && !qual.g6dv && qual.g7dv));
        m_status.dc2 = next_latch(m_status.dc2,
            ph == X7 && qual.dls && g.c2 == GT3 && g.c1 != GT3, clr_x7 || clr_y6);
        m_status.dc3 = next_latch(m_status.dc3,
            ph == X7 && qual.dls && qual.etcr && g.c3 == GT3, clr_x7 || clr_y6);
        m_status.dc4 = next_latch(m_status.dc4,
            ph == X7 && qual.dls && qual.etcr && qual.domc1 && g.c4 == GT3,
            clr_y6 || (ph == Y6 && qual.lgav && qual.pcav && qual.g2dv && !qual.g3dv
                       && !qual.etcr));
        ml_set = (ph == Y7 && qual.icsd && qual.pbg2v && qual.crcav && !ds.cr1)
              || (ph == Y7 && qual.paav && !qual.g1dv && !qual.g7dv && !qual.c4rdn)
              || (ph == X1 && qual.icsd && qual.pcg2v && qual.crcav && !ds.cr2)
              || (ph == Z2 && !qual.icsd && qual.crcav && qual.pbg2v && !ds.gc1)
              || (ph == Z2 && !ds.ssfb2 && qual.ssa && qual.pbg2v)
              || (ph == W2 && !qual.icsd && qual.crcav && qual.pcg2v && !ds.gc2)
              || (ph == Z2 && !ds.din11 && qual.pbg2v && qual.diad)
              || (ph == W2 && !ds.din12 && qual.pcg2v && qual.diad)
              || (ph == X1 && !ds.ssfb3 && qual.pcg2v && qual.ssa);
        m_status.ml1_2 = next_latch(m_status.ml1_2, ml_set,
            ph == Z2 && qual.resmv && qual.mlav);
        for (int i = SYNC_STAGES - 1; i > 0; i--) begin
            m_sync[i] = m_sync[i-1];
        end
        m_sync[0] = disc;
        if (ph == Z6) begin
            m_frame = (m_frame + 1) % 81;
        end
        m_slot = (m_slot + 1) % 8;
    endtask

    // outputs are settled at the falling edge, inputs changed half a cycle earlier
    always @(negedge sim_clk) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            check_phase(phase_t'(8'h80 >> m_slot), phase);
            check_gates(count_to_gates(m_frame), gates);
            check_status(m_status, status);
            // a hand-built row also has its final status checked in the V1 cycle after it
            if (end_pending) begin
                check_status(exp_end, status);
                end_pending = 1'b0;
            end
            step_model();
        end
    end

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task automatic add_row(input disc_t d, input qual_t q, input int frames,
                           input status_t s, input bit checked);
        row_disc.push_back(d);
        row_qual.push_back(q);
        row_frames.push_back(frames);
        row_status.push_back(s);
        row_checked.push_back(checked);
    endtask

    task automatic build_table();
        // the nine ML1_2 set terms in turn, each with only its own discrete low
        disc_t term_disc [9] = '{8'h7f, 8'hff, 8'hbf, 8'hdf, 8'hfd, 8'hef, 8'hf7, 8'hfb, 8'hfe};
        qual_t term_qual [9] = '{20'he0000, 20'h08000, 20'hd0000, 20'ha0000, 20'h20100,
                                 20'h90000, 20'h20200, 20'h10200, 20'h10100};
        // dc4 survives the first term only, the second term brings the Y6 clear with it
        status_t term_exp [9] = '{5'h03, 5'h01, 5'h01, 5'h01, 5'h01,
                                  5'h01, 5'h01, 5'h01, 5'h01};
        int    rnd;
        add_row(8'hff, 20'h00000, 2, 5'h00, 1'b1);
        add_row(8'hff, 20'h00000, 81, 5'h00, 1'b1);
        // dls etcr domc1 for a full period sets all four flags
        add_row(8'hff, 20'h01c00, 81, 5'h1e, 1'b1);
        add_row(8'hff, 20'h08001, 1, 5'h0e, 1'b1);
        add_row(8'hff, 20'h06008, 1, 5'h0c, 1'b1);
        add_row(8'hff, 20'h08000, 1, 5'h01, 1'b1);
        add_row(8'hff, 20'h01c00, 81, 5'h1f, 1'b1);
        // X7 clear against the dc1 and dc2 sets
        add_row(8'hff, 20'h13000, 27, 5'h03, 1'b1);
        add_row(8'hff, 20'h000c0, 1, 5'h02, 1'b1);
        for (int i = 0; i < 9; i++) begin
            add_row(term_disc[i], term_qual[i], 2, term_exp[i], 1'b1);
            add_row(8'hff, 20'h000c0, 1, term_exp[i] & 5'h1e, 1'b1);
        end
        add_row(term_disc[0], term_qual[0], 2, 5'h01, 1'b1);
        add_row(term_disc[3], term_qual[3] | 20'h000c0, 2, 5'h00, 1'b1);
        for (int i = 0; i < 12; i++) begin
            rnd = $urandom();
            add_row(rnd[7:0], rnd[27:8], 1 + rnd[29:28], '0, 1'b0);
        end
    endtask

    initial begin
        int total;
        arst_n = 1'b0;
        disc = '0;
        qual = '0;
        void'($urandom(SEED));
        build_table();
        total = 0;
        foreach (row_frames[i]) begin
            total += row_frames[i];
        end
        limit_cycles = total * 8 + 200;
        repeat (10) @(posedge sim_clk);
        arst_n <= 1'b1;
        // the release edge leaves the DUT in V1, so each row starts on a frame
        foreach (row_disc[i]) begin
            disc <= row_disc[i];
            qual <= row_qual[i];
            repeat (row_frames[i] * 8) @(posedge sim_clk);
            exp_end = row_status[i];
            end_pending = row_checked[i];
        end
        repeat (2) @(posedge sim_clk);
        $display("errors %0d, assertion failures %0d", errors,
                 u_sd_sampler_top.u_sd_sampler_sva.fail_cnt);
        if (errors == 0 && u_sd_sampler_top.u_sd_sampler_sva.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sim_clk);
        $display("run timed out before the stimulus table was finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/timing_pkg.sv
verilog/sampler_pkg.sv
verilog/phase_gen.sv
verilog/gate_counter.sv
verilog/dia_bank.sv
verilog/sd_sampler.sv
verilog/sd_sampler_top.sv
testbench/sd_sampler_sva.sv
testbench/tb_sd_sampler.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_sd_sampler -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "TEST PASS"; then
    exit 0
else
    exit 1
fi
